/* Bender.yml */
package:
  name: mips_core

sources:
  - mipsPkg.sv
  - controlDecoder.sv
  - registerFile.sv
  - hazardUnit.sv
  - executeUnit.sv
  - mipsCore.sv
  - target: simulation
    files:
      - mipsCore_tb.sv

/* controlDecoder.sv */
`timescale 1ns/1ps

module controlDecoder import mipsPkg::*; (
    input  word_t  instr,
    output logic   regWrite,
    output logic   regDst,
    output logic   zeroImm,
    output logic   aluSrc,
    output logic   memWrite,
    output logic   memToReg,
    output logic   luiOp,
    output logic   haltOp,
    output aluOp_t aluOp
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb
    begin
        // everything off unless the opcode says otherwise
        regWrite = 1'b0;
        regDst   = 1'b0;
        zeroImm  = 1'b0;
        aluSrc   = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        luiOp    = 1'b0;
        haltOp   = 1'b0;
        aluOp    = ALU_AND;

        case (opcode)
            OP_RTYPE:
            begin
                // all-zero word is a bubble, funct 0 matches nothing
                case (funct)
                    FN_ADD:  aluOp = ALU_ADD;
                    FN_SUB:  aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_SLT:  aluOp = ALU_SLT;
                    default: aluOp = ALU_AND;
                endcase
                regWrite = (funct == FN_ADD) || (funct == FN_SUB) || (funct == FN_AND)
                        || (funct == FN_OR) || (funct == FN_SLT);
                regDst   = regWrite;
            end
            OP_LW:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                aluOp    = ALU_ADD; // base + offset
            end
            OP_SW:
            begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                aluOp    = ALU_ADD;
            end
            OP_ADDI:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = ALU_ADD;
            end
            OP_ORI:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                zeroImm  = 1'b1;
                aluOp    = ALU_OR;
            end
            OP_LUI:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                luiOp    = 1'b1; // result replaced in execute
            end
            OP_MULI:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = ALU_MUL;
            end
            OP_HALT: haltOp = 1'b1;
            default: ;
        endcase
    end

    // a store never writes the register file
    noStoreWrite: assert final (!(memWrite && regWrite));

endmodule

/* executeUnit.sv */
`timescale 1ns/1ps

module executeUnit import mipsPkg::*; (
    input  word_t   regA,
    input  word_t   regB,
    input  word_t   memResult,
    input  word_t   wbResult,
    input  word_t   imm,
    input  fwdSel_t fwdA,
    input  fwdSel_t fwdB,
    input  logic    aluSrc,
    input  aluOp_t  aluOp,
    output word_t   aluResult,
    output word_t   storeData
);

    word_t srcA;
    word_t srcB;

    function automatic word_t operand(input fwdSel_t sel, input word_t reg_,
                                      input word_t mem, input word_t wb);
        case (sel)
            FWD_MEM: return mem;
            FWD_WB:  return wb;
            default: return reg_;
        endcase
    endfunction

    assign srcA      = operand(fwdA, regA, memResult, wbResult);
    assign storeData = operand(fwdB, regB, memResult, wbResult); // sw data
    assign srcB      = aluSrc ? imm : storeData;

    always_comb
    begin
        case (aluOp)
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_ADD: aluResult = srcA + srcB;
            ALU_SUB: aluResult = srcA - srcB;
            ALU_SLT: aluResult = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            ALU_MUL: aluResult = srcA * srcB; // upper product bits dropped
            default: aluResult = '0;
        endcase
    end

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
    input  regAddr_t rsD,
    input  regAddr_t rtD,
    input  regAddr_t rsE,
    input  regAddr_t rtE,
    input  regAddr_t destE,
    input  regAddr_t destM,
    input  regAddr_t destW,
    input  logic     usesRtD,
    input  logic     memToRegE,
    input  logic     regWriteM,
    input  logic     regWriteW,
    output fwdSel_t  fwdA,
    output fwdSel_t  fwdB,
    output logic     loadStall
);

    // younger result in memory wins over writeback
    function automatic fwdSel_t fwdSelect(input regAddr_t src);
        if (src == '0)
            return FWD_NONE;
        else if (regWriteM && (src == destM))
            return FWD_MEM;
        else if (regWriteW && (src == destW))
            return FWD_WB;
        else
            return FWD_NONE;
    endfunction

    always_comb
    begin
        fwdA = fwdSelect(rsE);
        fwdB = fwdSelect(rtE);
    end

    ////////////////////////////////////////
    // load-use
    ////////////////////////////////////////

    // load data only exists after memory, so decode waits one cycle
    assign loadStall = memToRegE && (destE != '0)
                    && ((rsD == destE) || (usesRtD && (rtD == destE)));

    memBeforeWb: assert final (!((fwdA == FWD_WB) && regWriteM
                                 && (rsE == destM) && (rsE != '0)));

endmodule

/* mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  instrValid,
    input  word_t instr,
    output logic  instrReady,
    output word_t sramAddress,
    output word_t sramWriteData,
    output logic  sramWriteEnable,
    input  word_t sramReadData,
    output logic  halt
);

    // decode
    word_t    instrD;
    logic     regWriteD, regDstD, zeroImmD, aluSrcD;
    logic     memWriteD, memToRegD, luiOpD, haltOpD;
    aluOp_t   aluOpD;
    regAddr_t rsD, rtD, destD;
    word_t    regDataAD, regDataBD, immD;
    logic     usesRtD;

    // execute
    logic     regWriteE, aluSrcE, memWriteE, memToRegE, luiOpE, haltE;
    aluOp_t   aluOpE;
    regAddr_t rsE, rtE, destE;
    word_t    regDataAE, regDataBE, immE;
    fwdSel_t  fwdA, fwdB;
    word_t    aluResultE, storeDataE, resultE;

    // memory and writeback
    logic     regWriteM, memWriteM, memToRegM, haltM;
    regAddr_t destM;
    word_t    resultM, storeDataM;
    logic     regWriteW, memToRegW, haltW;
    regAddr_t destW;
    word_t    resultW, loadDataW, writeDataW;

    logic     loadStall;
    logic     accept;
    logic     haltBusy;

    ////////////////////////////////////////
    // instruction intake
    ////////////////////////////////////////

    // a halt anywhere in flight closes the input for good
    assign haltBusy   = haltOpD || haltE || haltM || haltW || halt;
    assign instrReady = !(loadStall || haltBusy);
    assign accept     = instrValid && instrReady;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            instrD <= '0;
        else if (accept)
            instrD <= instr;
        else if (!loadStall)
            instrD <= '0; // no transfer, bubble
    end

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    controlDecoder u_controlDecoder (
        .instr    (instrD),
        .regWrite (regWriteD),
        .regDst   (regDstD),
        .zeroImm  (zeroImmD),
        .aluSrc   (aluSrcD),
        .memWrite (memWriteD),
        .memToReg (memToRegD),
        .luiOp    (luiOpD),
        .haltOp   (haltOpD),
        .aluOp    (aluOpD)
    );

    assign rsD     = instrD[25:21];
    assign rtD     = instrD[20:16];
    assign destD   = regDstD ? instrD[15:11] : rtD;
    assign immD    = zeroImmD ? {16'b0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};
    assign usesRtD = !aluSrcD || memWriteD; // r-type and sw read rt

    registerFile u_registerFile (
        .clk         (clk),
        .readAddrA   (rsD),
        .readAddrB   (rtD),
        .readDataA   (regDataAD),
        .readDataB   (regDataBD),
        .writeAddr   (destW),
        .writeEnable (regWriteW),
        .writeData   (writeDataW)
    );

    hazardUnit u_hazardUnit (
        .rsD       (rsD),
        .rtD       (rtD),
        .rsE       (rsE),
        .rtE       (rtE),
        .destE     (destE),
        .destM     (destM),
        .destW     (destW),
        .usesRtD   (usesRtD),
        .memToRegE (memToRegE),
        .regWriteM (regWriteM),
        .regWriteW (regWriteW),
        .fwdA      (fwdA),
        .fwdB      (fwdB),
        .loadStall (loadStall)
    );

    // decode to execute, stall sends a bubble
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            regWriteE <= 1'b0;
            aluSrcE   <= 1'b0;
            memWriteE <= 1'b0;
            memToRegE <= 1'b0;
            luiOpE    <= 1'b0;
            haltE     <= 1'b0;
            aluOpE    <= '0;
            rsE       <= '0;
            rtE       <= '0;
            destE     <= '0;
        end
        else
        begin
            regWriteE <= regWriteD && !loadStall;
            aluSrcE   <= aluSrcD && !loadStall;
            memWriteE <= memWriteD && !loadStall;
            memToRegE <= memToRegD && !loadStall;
            luiOpE    <= luiOpD && !loadStall;
            haltE     <= haltOpD && !loadStall;
            aluOpE    <= loadStall ? '0 : aluOpD;
            rsE       <= rsD;
            rtE       <= rtD;
            destE     <= destD;
        end
    end

    always_ff @(posedge clk)
    begin
        regDataAE <= regDataAD;
        regDataBE <= regDataBD;
        immE      <= immD;
    end

    ////////////////////////////////////////
    // execute
    ////////////////////////////////////////

    executeUnit u_executeUnit (
        .regA      (regDataAE),
        .regB      (regDataBE),
        .memResult (resultM),
        .wbResult  (writeDataW),
        .imm       (immE),
        .fwdA      (fwdA),
        .fwdB      (fwdB),
        .aluSrc    (aluSrcE),
        .aluOp     (aluOpE),
        .aluResult (aluResultE),
        .storeData (storeDataE)
    );

    assign resultE = luiOpE ? {immE[15:0], 16'b0} : aluResultE; // lui folded in here

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            regWriteM <= 1'b0;
            memWriteM <= 1'b0;
            memToRegM <= 1'b0;
            haltM     <= 1'b0;
            destM     <= '0;
        end
        else
        begin
            regWriteM <= regWriteE;
            memWriteM <= memWriteE;
            memToRegM <= memToRegE;
            haltM     <= haltE;
            destM     <= destE;
        end
    end

    always_ff @(posedge clk)
    begin
        resultM    <= resultE;
        storeDataM <= storeDataE;
    end

    ////////////////////////////////////////
    // memory and writeback
    ////////////////////////////////////////

    assign sramAddress     = resultM;
    assign sramWriteData   = storeDataM;
    assign sramWriteEnable = memWriteM;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
            haltW     <= 1'b0;
            destW     <= '0;
        end
        else
        begin
            regWriteW <= regWriteM;
            memToRegW <= memToRegM;
            haltW     <= haltM;
            destW     <= destM;
        end
    end

    always_ff @(posedge clk)
    begin
        resultW   <= resultM;
        loadDataW <= sramReadData;
    end

    assign writeDataW = memToRegW ? loadDataW : resultW;

    // sticky until reset
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            halt <= 1'b0;
        else if (haltW)
            halt <= 1'b1;
    end

    // the load has moved on to memory one cycle later
    stallOneCycle: assert property (@(posedge clk) disable iff (reset)
                                    loadStall |=> !loadStall);

    // older stores are drained before halt is seen
    noStoreAfterHalt: assert property (@(posedge clk) disable iff (reset)
                                       halt |-> !sramWriteEnable);

endmodule

/* mipsCore_tb.sv */
`timescale 1ns/1ps

module mipsCore_tb import mipsPkg::*; ();

    localparam int    TIMEOUT    = 200;
    localparam int    MAX_WORDS  = 256;
    localparam word_t BLOCKED_SW = 32'hAC01_0160; // sw $1,0x160($0) that must never be taken

    logic  clk;
    logic  reset;
    logic  instrValid;
    word_t instr;
    logic  instrReady;
    word_t sramAddress;
    word_t sramWriteData;
    logic  sramWriteEnable;
    word_t sramReadData;
    logic  halt;

    word_t records [MAX_WORDS];
    word_t dataMem [word_t];
    word_t instrQ [$];
    int    instrTestQ [$];
    word_t expAddrQ [$];
    word_t expDataQ [$];
    int    expTestQ [$];
    int    storesLeft [7];
    int    testErrors [7];
    int    stallCycles [7];
    int    curTest;
    int    memVersion;
    int    passCount;
    int    failCount;
    logic  aborted;
    logic  pendingWrite;
    word_t pendingAddr;
    word_t pendingData;

    mipsCore u_mipsCore (
        .clk             (clk),
        .reset           (reset),
        .instrValid      (instrValid),
        .instr           (instr),
        .instrReady      (instrReady),
        .sramAddress     (sramAddress),
        .sramWriteData   (sramWriteData),
        .sramWriteEnable (sramWriteEnable),
        .sramReadData    (sramReadData),
        .halt            (halt)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////
    // data memory model
    ////////////////////////////////////////

    function automatic word_t fillWord(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3; // untouched locations
    endfunction

    always @(sramAddress or memVersion)
    begin
        if ($isunknown(sramAddress))
            sramReadData = '0;
        else if (dataMem.exists(sramAddress))
            sramReadData = dataMem[sramAddress];
        else
            sramReadData = fillWord(sramAddress);
    end

    task automatic checkStore(input word_t addr, input word_t data);
        int    t;
        word_t ea;
        word_t ed;
        if (expAddrQ.size() == 0)
        begin
            $display("unexpected store of %h to address %h", data, addr);
            testErrors[curTest]++;
            return;
        end
        t  = expTestQ.pop_front();
        ea = expAddrQ.pop_front();
        ed = expDataQ.pop_front();
        storesLeft[t]--;
        if (addr !== ea || data !== ed)
        begin
            $display("ERROR %s: expected %h at %h, actual %h at %h",
                     testName(t), ed, ea, data, addr);
            testErrors[t]++;
        end
    endtask

    // memory stage outputs are settled by the falling edge
    always @(negedge clk)
    begin
        if (!reset && sramWriteEnable)
        begin
            checkStore(sramAddress, sramWriteData);
            pendingWrite = 1'b1;
            pendingAddr  = sramAddress;
            pendingData  = sramWriteData;
        end
    end

    always @(posedge clk)
    begin
        if (pendingWrite)
        begin
            dataMem[pendingAddr] = pendingData;
            memVersion++;
            pendingWrite = 1'b0;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic string testName(input int t);
        case (t)
            1:       return "rtype alu";
            2:       return "immediates";
            3:       return "forwarding";
            4:       return "load use";
            5:       return "idle gaps";
            6:       return "halt and reset";
            default: return "unknown";
        endcase
    endfunction

    // four words per record (kind, test, a, b)
    task automatic loadProgram();
        int idx;
        idx = 0;
        $readmemh("program_input.mem", records);
        while (idx + 3 < MAX_WORDS && !$isunknown(records[idx]) && records[idx] != 0)
        begin
            case (records[idx])
                1: dataMem[records[idx+2]] = records[idx+3];
                2:
                begin
                    instrQ.push_back(records[idx+2]);
                    instrTestQ.push_back(int'(records[idx+1]));
                end
                3:
                begin
                    expAddrQ.push_back(records[idx+2]);
                    expDataQ.push_back(records[idx+3]);
                    expTestQ.push_back(int'(records[idx+1]));
                    storesLeft[records[idx+1]]++;
                end
                default:
                begin
                    $display("bad record kind %h in the program file", records[idx]);
                    aborted = 1'b1;
                end
            endcase
            idx += 4;
        end
        if (instrQ.size() == 0)
        begin
            $display("no instructions found in the program file");
            aborted = 1'b1;
        end
    endtask

    // holds instr until the core takes it
    task automatic sendInstr(input word_t w, input int t);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        if (aborted)
            return;
        instrValid = 1'b1;
        instr      = w;
        while (!taken && waited < TIMEOUT)
        begin
            @(negedge clk);
            if (instrReady)
                taken = 1'b1;
            else
            begin
                stallCycles[t]++;
                waited++;
            end
        end
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        if (!taken)
        begin
            $display("timeout: instruction %h of test %s was never accepted", w, testName(t));
            aborted = 1'b1;
        end
    endtask

    task automatic finishTest(input int t);
        int waited;
        waited = 0;
        if (aborted)
            return;
        while (storesLeft[t] > 0 && waited < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (storesLeft[t] > 0)
        begin
            $display("timeout: test %s still misses %0d stores", testName(t), storesLeft[t]);
            aborted = 1'b1;
            return;
        end
        if (t == 4 && stallCycles[4] == 0)
        begin
            $display("test %s: instrReady never dropped for the load-use", testName(t));
            testErrors[t]++;
        end
        if (testErrors[t] == 0)
        begin
            $display("PASS %s", testName(t));
            passCount++;
        end
        else
        begin
            $display("FAIL %s with %0d errors", testName(t), testErrors[t]);
            failCount++;
        end
    endtask

    task automatic checkHaltAndReset();
        int waited;
        waited = 0;
        instrValid = 1'b1; // offered but never accepted
        instr      = BLOCKED_SW;
        while (!halt && waited < TIMEOUT)
        begin
            @(negedge clk);
            if (instrReady)
            begin
                $display("instrReady went high while the halt was in flight");
                testErrors[6]++;
            end
            waited++;
        end
        if (!halt)
        begin
            $display("timeout: halt never rose");
            aborted = 1'b1;
            return;
        end
        repeat (20)
        begin
            @(negedge clk);
            if (instrReady)
            begin
                $display("instrReady went high after the halt");
                testErrors[6]++;
            end
        end
        if (expAddrQ.size() != 0)
        begin
            $display("%0d expected stores never happened", expAddrQ.size());
            testErrors[6]++;
        end
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        reset      = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        if (!instrReady || sramWriteEnable || halt)
        begin
            $display("after reset: instrReady %b, sramWriteEnable %b, halt %b",
                     instrReady, sramWriteEnable, halt);
            testErrors[6]++;
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial
    begin
        int idle;
        reset        = 1'b1;
        instrValid   = 1'b0;
        instr        = '0;
        sramReadData = '0;
        memVersion   = 0;
        passCount    = 0;
        failCount    = 0;
        aborted      = 1'b0;
        pendingWrite = 1'b0;
        curTest      = 0;
        void'($urandom(32'h838430e1));
        loadProgram();

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        if (!aborted)
            curTest = instrTestQ[0];
        for (int i = 0; i < instrQ.size() && !aborted; i++)
        begin
            if (instrTestQ[i] != curTest)
            begin
                finishTest(curTest);
                curTest = instrTestQ[i];
            end
            if (curTest == 5)
            begin
                idle = $urandom % 4; // gaps on instrValid
                repeat (idle)
                begin
                    @(posedge clk);
                    #1;
                end
            end
            sendInstr(instrQ[i], curTest);
        end

        // last record is the halt
        if (!aborted)
            checkHaltAndReset();
        finishTest(6);

        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && !aborted)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* mipsPkg.sv */
package mipsPkg;

    ////////////////////////////////////////
    // basic types
    ////////////////////////////////////////

    typedef logic [31:0] word_t;    // data or instruction word
    typedef logic [4:0]  regAddr_t; // general register number
    typedef logic [3:0]  aluOp_t;
    typedef logic [1:0]  fwdSel_t;

    ////////////////////////////////////////
    // alu operations
    ////////////////////////////////////////

    localparam aluOp_t ALU_AND = 4'b0000;
    localparam aluOp_t ALU_OR  = 4'b0001;
    localparam aluOp_t ALU_ADD = 4'b0010;
    localparam aluOp_t ALU_SUB = 4'b0110;
    localparam aluOp_t ALU_SLT = 4'b0111;
    localparam aluOp_t ALU_MUL = 4'b1000; // low word of the product

    // operand source seen by execute
    localparam fwdSel_t FWD_NONE = 2'b00;
    localparam fwdSel_t FWD_WB   = 2'b01;
    localparam fwdSel_t FWD_MEM  = 2'b10;

    ////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////

    // opcode field, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_LUI   = 6'b001111;
    localparam logic [5:0] OP_MULI  = 6'b001010;
    localparam logic [5:0] OP_HALT  = 6'b001110;

    // function field of r-type, instr[5:0]
    localparam logic [5:0] FN_ADD = 6'b100000;
    localparam logic [5:0] FN_SUB = 6'b100010;
    localparam logic [5:0] FN_AND = 6'b100100;
    localparam logic [5:0] FN_OR  = 6'b100101;
    localparam logic [5:0] FN_SLT = 6'b101010;

endpackage

/* program_input.mem */
// kind test a b; kind 1 preload (a address, b word), 2 instruction (a word),
// 3 expected store (a address, b word), 0 ends the list
1 0 00000200 00001000
1 0 00000204 00000234
2 1 2001000C 0 // addi $1,$0,12
2 1 2002000A 0 // addi $2,$0,10
2 1 2009FFFB 0 // addi $9,$0,-5
2 1 00221820 0 // add $3,$1,$2
2 1 00412022 0 // sub $4,$2,$1
2 1 00222824 0 // and $5,$1,$2
2 1 00223025 0 // or $6,$1,$2
2 1 0121382A 0 // slt $7,$9,$1
2 1 AC030100 0 // sw $3,0x100($0)
2 1 AC040104 0 // sw $4,0x104($0)
2 1 AC050108 0 // sw $5,0x108($0)
2 1 AC06010C 0 // sw $6,0x10c($0)
2 1 AC070110 0 // sw $7,0x110($0)
3 1 00000100 00000016
3 1 00000104 FFFFFFFE
3 1 00000108 00000008
3 1 0000010C 0000000E
3 1 00000110 00000001
2 2 340A8001 0 // ori $10,$0,0x8001
2 2 200B8001 0 // addi $11,$0,0x8001
2 2 3C0C1234 0 // lui $12,0x1234
2 2 282DFFFD 0 // muli $13,$1,-3
2 2 AC0A0120 0 // sw $10,0x120($0)
2 2 AC0B0124 0 // sw $11,0x124($0)
2 2 AC0C0128 0 // sw $12,0x128($0)
2 2 AC0D012C 0 // sw $13,0x12c($0)
3 2 00000120 00008001
3 2 00000124 FFFF8001
3 2 00000128 12340000
3 2 0000012C FFFFFFDC
2 3 200E0005 0 // addi $14,$0,5
2 3 21CE0006 0 // addi $14,$14,6
2 3 01CE7820 0 // add $15,$14,$14
2 3 20000009 0 // addi $0,$0,9
2 3 01CF8020 0 // add $16,$14,$15
2 3 AC000134 0 // sw $0,0x134($0)
2 3 AC100130 0 // sw $16,0x130($0)
3 3 00000134 00000000
3 3 00000130 00000021
2 4 8C110200 0 // lw $17,0x200($0)
2 4 02219020 0 // add $18,$17,$1
2 4 8C130204 0 // lw $19,0x204($0)
2 4 AC130140 0 // sw $19,0x140($0)
2 4 AC120144 0 // sw $18,0x144($0)
3 4 00000140 00000234
3 4 00000144 0000100C
2 5 20140064 0 // addi $20,$0,100
2 5 8C150200 0 // lw $21,0x200($0)
2 5 0295B020 0 // add $22,$20,$21
2 5 AC160200 0 // sw $22,0x200($0)
2 5 8C170200 0 // lw $23,0x200($0)
2 5 AC170150 0 // sw $23,0x150($0)
3 5 00000200 00001064
3 5 00000150 00001064
2 6 38000000 0 // halt
0 0 00000000 00000000

/* registerFile.sv */
`timescale 1ns/1ps

module registerFile import mipsPkg::*; (
    input  logic     clk,
    input  regAddr_t readAddrA,
    input  regAddr_t readAddrB,
    output word_t    readDataA,
    output word_t    readDataB,
    input  regAddr_t writeAddr,
    input  logic     writeEnable,
    input  word_t    writeData
);

    word_t regs [32];

    // one read port, $0 is hardwired and a same-cycle write bypasses the array
    function automatic word_t readPort(input regAddr_t addr);
        if (addr == '0)
            return '0;
        else if (writeEnable && (writeAddr == addr))
            return writeData;
        else
            return regs[addr];
    endfunction

    always_comb
    begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

    always_ff @(posedge clk)
    begin
        if (writeEnable && (writeAddr != '0))
            regs[writeAddr] <= writeData;
    end

endmodule

/* sim.f */
mipsPkg.sv
controlDecoder.sv
registerFile.sv
hazardUnit.sv
executeUnit.sv
mipsCore.sv
mipsCore_tb.sv
